// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run tb_top, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top \
		-Mdir obj_dir -o tb_top_sim
	./obj_dir/tb_top_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/system_props.sv ====
`timescale 1ns/1ps

module system_props (
	input logic clk_24,
	input logic reset,
	input sys_pkg::bus_req_t req,
	input logic ack
);

	// ack is a one cycle pulse
	ack_single_cycle: assert property (@(posedge clk_24) disable iff (reset) ack |=> !ack)
		else $error("ack high for two cycles in a row");

	// reset clears ack by the next edge
	ack_low_after_reset: assert property (@(posedge clk_24) reset |=> !ack)
		else $error("ack high right after a reset edge");

	// fixed two cycle latency from the request pulse
	ack_follows_valid: assert property (@(posedge clk_24) disable iff (reset)
		ack |-> $past(req.valid, 2))
		else $error("ack without a valid request two cycles earlier");

endmodule

bind read_response system_props u_system_props (
	.clk_24(clk_24),
	.reset(reset),
	.req(req),
	.ack(ack)
);

// ==== dv/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

	// one wishbone classic cycle, held until ack
	task automatic bus_cycle(
		input logic wr,
		input sys_pkg::cpu_addr_t a,
		input sys_pkg::byte_t wd,
		output sys_pkg::byte_t rd
	);
		int waited;
		waited = 0;
		@(negedge clk_24);
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = a;
		dat_w = wd;
		do
		begin
			@(negedge clk_24);
			waited++;
			if (waited > ACK_TIMEOUT)
				fail_stop($sformatf("no ack from the DUT for address %h", a));
		end
		while (!ack);
		rd = dat_r;
		// master lets go once ack is seen
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		check_equal($sformatf("ack latency at %h", a), waited, ACK_LATENCY);
	endtask

	task automatic bus_write(input sys_pkg::cpu_addr_t a, input sys_pkg::byte_t d);
		sys_pkg::byte_t ignored;
		bus_cycle(1'b1, a, d, ignored);
	endtask

	task automatic read_expect(
		input sys_pkg::cpu_addr_t a,
		input sys_pkg::byte_t want,
		input string what
	);
		sys_pkg::byte_t got;
		bus_cycle(1'b0, a, 8'h00, got);
		check_equal($sformatf("%s dat_r at %h", what, a), got, want);
	endtask

	// single download strobe
	task automatic dl_write(
		input sys_pkg::dl_addr_t a,
		input sys_pkg::byte_t d,
		input logic [7:0] idx
	);
		@(negedge clk_24);
		dl.addr = a;
		dl.data = d;
		dl.index = idx;
		dl.wr = 1'b1;
		@(negedge clk_24);
		dl.wr = 1'b0;
	endtask

	task automatic test_rom_download();
		sys_pkg::cpu_addr_t rom_addr [4];
		sys_pkg::byte_t rom_data [4];
		rom_addr = '{16'h0000, 16'h0001, 16'h1234, 16'h7fff};
		for (int i = 0; i < 4; i++)
		begin
			rom_data[i] = sys_pkg::byte_t'(next_random());
			dl_write(sys_pkg::dl_addr_t'(rom_addr[i]), rom_data[i], sys_pkg::DL_INDEX_PGROM);
		end
		// index 3 belongs to another image
		dl_write(17'h01234, ~rom_data[2], 8'd3);
		for (int i = 0; i < 4; i++)
			read_expect(rom_addr[i], rom_data[i], "pgrom");
	endtask

	task automatic test_ram_round_trip();
		sys_pkg::cpu_addr_t ram_addr [4];
		sys_pkg::byte_t ram_data [4];
		logic [31:0] r;
		// offset 123 in wkram, chram, fgcolram, bgcolram
		ram_addr = '{16'hc123, 16'h9923, 16'ha123, 16'ha923};
		r = next_random();
		for (int i = 0; i < 4; i++)
		begin
			// low bits hold the bank number so no two bytes match
			ram_data[i] = {r[8*i+2 +: 6], 2'(i)};
			bus_write(ram_addr[i], ram_data[i]);
		end
		for (int i = 0; i < 4; i++)
			read_expect(ram_addr[i], ram_data[i], "ram round trip");
	endtask

	function automatic logic [255:0] random_pattern();
		logic [255:0] p;
		for (int k = 0; k < 8; k++)
			p[32*k +: 32] = next_random();
		return p;
	endfunction

	// byte idx of the first width bits of pat, zero past the width
	function automatic sys_pkg::byte_t expected_byte(
		input logic [255:0] pat,
		input int width,
		input int idx
	);
		sys_pkg::byte_t b;
		for (int k = 0; k < 8; k++)
			b[k] = (idx * 8 + k < width) ? pat[idx * 8 + k] : 1'b0;
		return b;
	endfunction

	task automatic read_input_bytes(
		input string name,
		input logic [7:0] page,
		input logic [255:0] pat,
		input int width,
		input int count
	);
		for (int i = 0; i < count; i++)
			read_expect({page, 8'(i)}, expected_byte(pat, width, i),
				$sformatf("%s byte %0d", name, i));
	endtask

	task automatic test_input_readback();
		logic [255:0] joy_pat;
		logic [255:0] pad_pat;
		logic [255:0] key_pat;
		logic [255:0] ts_pat;
		joy_pat = random_pattern();
		pad_pat = random_pattern();
		key_pat = random_pattern();
		ts_pat = random_pattern();
		joystick = joy_pat[sys_pkg::JOY_W-1:0];
		paddle = pad_pat[sys_pkg::PADDLE_W-1:0];
		ps2_key = key_pat[sys_pkg::PS2_KEY_W-1:0];
		timestamp = ts_pat[sys_pkg::TIMESTAMP_W-1:0];
		read_input_bytes("joystick", 8'h81, joy_pat, sys_pkg::JOY_W, 32);
		read_input_bytes("paddle", 8'h84, pad_pat, sys_pkg::PADDLE_W, 8);
		read_input_bytes("ps2_key", 8'h86, key_pat, sys_pkg::PS2_KEY_W, 2);
		read_input_bytes("timestamp", 8'h88, ts_pat, sys_pkg::TIMESTAMP_W, 8);
	endtask

	task automatic test_ignored_targets();
		sys_pkg::byte_t b;
		b = sys_pkg::byte_t'(next_random());
		dl_write(17'h00100, b, sys_pkg::DL_INDEX_PGROM);
		// rom is read only from the bus side
		bus_write(16'h0100, ~b);
		read_expect(16'h0100, b, "pgrom after bus write");
		read_expect(16'h9000, 8'h00, "unmapped");
	endtask

	task automatic test_ms_timer();
		bus_write(16'h8900, 8'h00);
		// 3.5 ms after the clear
		repeat (3 * sys_pkg::TIMER_PRESCALE + sys_pkg::TIMER_PRESCALE / 2) @(negedge clk_24);
		read_expect(16'h8900, 8'd3, "timer low");
		read_expect(16'h8901, 8'd0, "timer high");
		bus_write(16'h8900, 8'h00);
		read_expect(16'h8900, 8'd0, "timer low after clear");
	endtask

`endif

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	// accept edge plus two, counted in falling edges after the drive
	localparam int ACK_LATENCY = 3;
	localparam int ACK_TIMEOUT = 10;
	// timer test waits 3.5 ms, the rest is a few hundred cycles
	localparam int WATCHDOG_CYCLES = 5 * sys_pkg::TIMER_PRESCALE;

	logic clk_24 = 1'b0;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	sys_pkg::cpu_addr_t adr;
	sys_pkg::byte_t dat_w;
	sys_pkg::byte_t dat_r;
	logic ack;
	sys_pkg::dl_t dl;
	logic [sys_pkg::JOY_W-1:0] joystick;
	logic [sys_pkg::PADDLE_W-1:0] paddle;
	logic [sys_pkg::PS2_KEY_W-1:0] ps2_key;
	logic [sys_pkg::TIMESTAMP_W-1:0] timestamp;

	// data pattern source
	logic [31:0] rng_state = 32'h9f54729b;

	// 100 MHz sim clock
	always #5 clk_24 = ~clk_24;

	system_top dut (
		.clk_24(clk_24),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.dl(dl),
		.joystick(joystick),
		.paddle(paddle),
		.ps2_key(ps2_key),
		.timestamp(timestamp)
	);

	// xorshift32
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_equal(
		input string what,
		input logic [31:0] got,
		input logic [31:0] want
	);
		if (got !== want)
			fail_stop($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", what, got, want));
	endtask

	`include "tb_tasks.svh"

	// hang guard
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_24);
		fail_stop("watchdog expired before the test sequence finished");
	end

	initial
	begin
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		dl = '0;
		joystick = '0;
		paddle = '0;
		ps2_key = '0;
		timestamp = '0;
		// four rising edges in reset
		repeat (4) @(negedge clk_24);
		reset = 1'b0;
		test_rom_download();
		test_ram_round_trip();
		test_input_readback();
		test_ignored_targets();
		test_ms_timer();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
	input logic clk_24,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input sys_pkg::cpu_addr_t adr,
	input sys_pkg::byte_t dat_w,
	input logic done,
	output sys_pkg::bus_req_t req
);

	typedef enum logic {
		idle,
		busy
	} state_t;

	state_t state;

	// 64k map to target region, unlisted addresses fall to reg_none
	function automatic sys_pkg::region_t decode(input sys_pkg::cpu_addr_t a);
		sys_pkg::region_t r;
		r = sys_pkg::reg_none;
		if (a[15:sys_pkg::PGROM_AW] == sys_pkg::PGROM_BASE[15:sys_pkg::PGROM_AW])
			r = sys_pkg::reg_pgrom;
		else if (a[15:sys_pkg::WKRAM_AW] == sys_pkg::WKRAM_BASE[15:sys_pkg::WKRAM_AW])
			r = sys_pkg::reg_wkram;
		else if (a[15:sys_pkg::CHRAM_AW] == sys_pkg::CHRAM_BASE[15:sys_pkg::CHRAM_AW])
			r = sys_pkg::reg_chram;
		else if (a[15:sys_pkg::CHRAM_AW] == sys_pkg::FGCOLRAM_BASE[15:sys_pkg::CHRAM_AW])
			r = sys_pkg::reg_fgcolram;
		else if (a[15:sys_pkg::CHRAM_AW] == sys_pkg::BGCOLRAM_BASE[15:sys_pkg::CHRAM_AW])
			r = sys_pkg::reg_bgcolram;
		else
		begin
			// input pages are 256 bytes each
			case (a[15:8])
				sys_pkg::PAGE_JOYSTICK: r = sys_pkg::reg_joystick;
				sys_pkg::PAGE_PADDLE: r = sys_pkg::reg_paddle;
				sys_pkg::PAGE_PS2_KEY: r = sys_pkg::reg_ps2_key;
				sys_pkg::PAGE_TIMESTAMP: r = sys_pkg::reg_timestamp;
				sys_pkg::PAGE_TIMER: r = sys_pkg::reg_timer;
				default: r = sys_pkg::reg_none;
			endcase
		end
		return r;
	endfunction

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			state <= idle;
			req.valid <= 1'b0;
		end
		else
		begin
			// valid is a single cycle pulse
			req.valid <= 1'b0;
			case (state)
				idle:
				begin
					if (cyc && stb)
					begin
						req.region <= decode(adr);
						req.addr <= adr;
						req.we <= we;
						req.wdata <= dat_w;
						req.valid <= 1'b1;
						state <= busy;
					end
				end
				busy:
				begin
					// ack is high this cycle, master drops stb before the next edge
					if (done)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

// ==== logic/input_ports.sv ====
`timescale 1ns/1ps

module input_ports (
	input logic clk_24,
	input logic reset,
	input sys_pkg::bus_req_t req,
	input logic [sys_pkg::JOY_W-1:0] joystick,
	input logic [sys_pkg::PADDLE_W-1:0] paddle,
	input logic [sys_pkg::PS2_KEY_W-1:0] ps2_key,
	input logic [sys_pkg::TIMESTAMP_W-1:0] timestamp,
	output sys_pkg::byte_t io_rdata
);

	localparam sys_pkg::prescale_t PRESCALE_LAST =
		sys_pkg::prescale_t'(sys_pkg::TIMER_PRESCALE - 1);

	sys_pkg::prescale_t prescale;
	sys_pkg::timer_t timer;

	logic timer_clr;
	logic rd;

	// byte idx of a zero padded source
	// bytes past the real width come out as zero
	function automatic sys_pkg::byte_t pick_byte(
		input sys_pkg::pick_src_t src,
		input sys_pkg::byte_sel_t idx
	);
		return src[{idx, 3'd0} +: 8];
	endfunction

	// any write to the timer page clears it
	assign timer_clr = req.valid && req.we && (req.region == sys_pkg::reg_timer);
	assign rd = req.valid && !req.we;

	// millisecond timer
	always_ff @(posedge clk_24)
	begin
		if (reset || timer_clr)
		begin
			prescale <= '0;
			timer <= '0;
		end
		else if (prescale == PRESCALE_LAST)
		begin
			prescale <= '0;
			// wraps after ~65 s
			timer <= timer + 16'd1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

	// byte readback, low address bits pick the byte
	always_ff @(posedge clk_24)
	begin
		if (rd)
		begin
			case (req.region)
				sys_pkg::reg_joystick:
					io_rdata <= pick_byte(sys_pkg::pick_src_t'(joystick),
						sys_pkg::byte_sel_t'(req.addr[sys_pkg::JOY_SEL_W-1:0]));
				sys_pkg::reg_paddle:
					io_rdata <= pick_byte(sys_pkg::pick_src_t'(paddle),
						sys_pkg::byte_sel_t'(req.addr[sys_pkg::PADDLE_SEL_W-1:0]));
				// bit 10 toggles, 9 pressed, 8 extended
				sys_pkg::reg_ps2_key:
					io_rdata <= pick_byte(sys_pkg::pick_src_t'(ps2_key),
						sys_pkg::byte_sel_t'(req.addr[sys_pkg::PS2_KEY_SEL_W-1:0]));
				// byte 4 only holds the change toggle bit
				sys_pkg::reg_timestamp:
					io_rdata <= pick_byte(sys_pkg::pick_src_t'(timestamp),
						sys_pkg::byte_sel_t'(req.addr[sys_pkg::TIMESTAMP_SEL_W-1:0]));
				// low byte at 8900, high byte at 8901
				sys_pkg::reg_timer:
					io_rdata <= pick_byte(sys_pkg::pick_src_t'(timer),
						sys_pkg::byte_sel_t'(req.addr[sys_pkg::TIMER_SEL_W-1:0]));
				default: io_rdata <= '0;
			endcase
		end
	end

endmodule

// ==== logic/memory_banks.sv ====
`timescale 1ns/1ps

module memory_banks (
	input logic clk_24,
	input logic reset,
	input sys_pkg::bus_req_t req,
	input sys_pkg::dl_t dl,
	output sys_pkg::byte_t mem_rdata
);

	localparam int PGROM_DEPTH = 1 << sys_pkg::PGROM_AW;
	localparam int WKRAM_DEPTH = 1 << sys_pkg::WKRAM_AW;
	localparam int CHRAM_DEPTH = 1 << sys_pkg::CHRAM_AW;

	// program rom, 0000-7fff, loaded from the download port
	sys_pkg::byte_t pgrom [0:PGROM_DEPTH-1];
	// work ram, c000-ffff
	sys_pkg::byte_t wkram [0:WKRAM_DEPTH-1];
	// char index, fg colour and bg colour, one 2k bank each
	sys_pkg::byte_t char_ram [0:2][0:CHRAM_DEPTH-1];

	sys_pkg::byte_t pgrom_q;
	sys_pkg::byte_t wkram_q;
	sys_pkg::byte_t char_q;
	// region of the read held in the q registers
	sys_pkg::region_t sel_region;

	logic pgrom_dl_we;
	logic wkram_we;
	logic char_hit;
	logic char_we;
	logic [1:0] char_bank;

	// only index 0 targets the program rom
	assign pgrom_dl_we = dl.wr && (dl.index == sys_pkg::DL_INDEX_PGROM);
	assign wkram_we = req.valid && req.we && (req.region == sys_pkg::reg_wkram);
	assign char_we = req.valid && req.we && char_hit;

	// bank number of the three character side rams
	always_comb
	begin
		char_hit = 1'b1;
		char_bank = 2'd0;
		case (req.region)
			sys_pkg::reg_chram: char_bank = 2'd0;
			sys_pkg::reg_fgcolram: char_bank = 2'd1;
			sys_pkg::reg_bgcolram: char_bank = 2'd2;
			default: char_hit = 1'b0;
		endcase
	end

	// bus writes never reach the rom
	always_ff @(posedge clk_24)
	begin
		if (pgrom_dl_we)
			pgrom[dl.addr[sys_pkg::PGROM_AW-1:0]] <= dl.data;
		pgrom_q <= pgrom[req.addr[sys_pkg::PGROM_AW-1:0]];
	end

	// read before write on the same address
	always_ff @(posedge clk_24)
	begin
		if (wkram_we)
			wkram[req.addr[sys_pkg::WKRAM_AW-1:0]] <= req.wdata;
		wkram_q <= wkram[req.addr[sys_pkg::WKRAM_AW-1:0]];
	end

	always_ff @(posedge clk_24)
	begin
		if (char_we)
			char_ram[char_bank][req.addr[sys_pkg::CHRAM_AW-1:0]] <= req.wdata;
		char_q <= char_ram[char_bank][req.addr[sys_pkg::CHRAM_AW-1:0]];
	end

	// follows the q registers by the same edge
	always_ff @(posedge clk_24)
	begin
		if (reset)
			sel_region <= sys_pkg::reg_none;
		else
			sel_region <= req.region;
	end

	// input regions and unmapped space read zero here
	always_comb
	begin
		case (sel_region)
			sys_pkg::reg_pgrom: mem_rdata = pgrom_q;
			sys_pkg::reg_wkram: mem_rdata = wkram_q;
			sys_pkg::reg_chram,
			sys_pkg::reg_fgcolram,
			sys_pkg::reg_bgcolram: mem_rdata = char_q;
			default: mem_rdata = '0;
		endcase
	end

endmodule

// ==== logic/read_response.sv ====
`timescale 1ns/1ps

module read_response (
	input logic clk_24,
	input logic reset,
	input sys_pkg::bus_req_t req,
	input sys_pkg::byte_t mem_rdata,
	input sys_pkg::byte_t io_rdata,
	output sys_pkg::byte_t dat_r,
	output logic ack,
	output logic done
);

	// one stage behind req, lines up with the registered read data
	logic valid_d;
	sys_pkg::region_t region_d;
	sys_pkg::byte_t rdata;

	always_ff @(posedge clk_24)
	begin
		if (reset)
			valid_d <= 1'b0;
		else
			valid_d <= req.valid;
		region_d <= req.region;
	end

	// source of the read byte
	always_comb
	begin
		case (region_d)
			sys_pkg::reg_joystick,
			sys_pkg::reg_paddle,
			sys_pkg::reg_ps2_key,
			sys_pkg::reg_timestamp,
			sys_pkg::reg_timer: rdata = io_rdata;
			sys_pkg::reg_none: rdata = '0;
			default: rdata = mem_rdata;
		endcase
	end

	// ack two edges after acceptance, for reads and writes alike
	always_ff @(posedge clk_24)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= valid_d;
		if (valid_d)
			dat_r <= rdata;
	end

	// frees the decoder
	assign done = ack;

endmodule

// ==== logic/sys_pkg.sv ====
package sys_pkg;

	// cpu side widths
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] byte_t;
	// download port address, covers all rom images
	typedef logic [16:0] dl_addr_t;

	// memory address widths
	localparam int PGROM_AW = 15;
	localparam int WKRAM_AW = 14;
	// chram, fgcolram and bgcolram all use this
	localparam int CHRAM_AW = 11;

	// base of each memory window in the cpu map
	localparam cpu_addr_t PGROM_BASE = 16'h0000;
	localparam cpu_addr_t CHRAM_BASE = 16'h9800;
	localparam cpu_addr_t FGCOLRAM_BASE = 16'hA000;
	localparam cpu_addr_t BGCOLRAM_BASE = 16'hA800;
	localparam cpu_addr_t WKRAM_BASE = 16'hC000;

	// input pages, matched on adr[15:8]
	localparam logic [7:0] PAGE_JOYSTICK = 8'h81;
	localparam logic [7:0] PAGE_PADDLE = 8'h84;
	localparam logic [7:0] PAGE_PS2_KEY = 8'h86;
	localparam logic [7:0] PAGE_TIMESTAMP = 8'h88;
	localparam logic [7:0] PAGE_TIMER = 8'h89;

	// raw input widths
	localparam int JOY_W = 192;
	localparam int PADDLE_W = 48;
	localparam int PS2_KEY_W = 11;
	localparam int TIMESTAMP_W = 33;

	// byte index bits taken from the low address
	localparam int JOY_SEL_W = 5;
	localparam int PADDLE_SEL_W = 3;
	localparam int PS2_KEY_SEL_W = 1;
	localparam int TIMESTAMP_SEL_W = 3;
	localparam int TIMER_SEL_W = 1;
	// widest index, every input is padded up to this many bytes
	localparam int BYTE_SEL_W = 5;
	localparam int PICK_W = 8 << BYTE_SEL_W;
	typedef logic [BYTE_SEL_W-1:0] byte_sel_t;
	typedef logic [PICK_W-1:0] pick_src_t;

	// download index of the program rom image
	localparam logic [7:0] DL_INDEX_PGROM = 8'd0;

	// clk_24 cycles per millisecond
	localparam int TIMER_PRESCALE = 24000;
	localparam int PRESCALE_W = $clog2(TIMER_PRESCALE);
	typedef logic [PRESCALE_W-1:0] prescale_t;
	typedef logic [15:0] timer_t;

	typedef enum logic [3:0] {
		reg_pgrom,
		reg_joystick,
		reg_paddle,
		reg_ps2_key,
		reg_timestamp,
		reg_timer,
		reg_chram,
		reg_fgcolram,
		reg_bgcolram,
		reg_wkram,
		reg_none
	} region_t;

	// one accepted bus transfer
	typedef struct packed {
		region_t region;
		cpu_addr_t addr;
		logic we;
		byte_t wdata;
		logic valid;
	} bus_req_t;

	typedef struct packed {
		dl_addr_t addr;
		byte_t data;
		logic [7:0] index;
		logic wr;
	} dl_t;

endpackage

// ==== logic/system_top.sv ====
`timescale 1ns/1ps

module system_top (
	input logic clk_24,
	input logic reset,
	// wishbone classic slave
	input logic cyc,
	input logic stb,
	input logic we,
	input sys_pkg::cpu_addr_t adr,
	input sys_pkg::byte_t dat_w,
	output sys_pkg::byte_t dat_r,
	output logic ack,
	// rom download port
	input sys_pkg::dl_t dl,
	// 6 pads, 32 buttons each
	input logic [sys_pkg::JOY_W-1:0] joystick,
	// 6 paddles, 8 bits each
	input logic [sys_pkg::PADDLE_W-1:0] paddle,
	input logic [sys_pkg::PS2_KEY_W-1:0] ps2_key,
	// unix seconds plus a toggle bit
	input logic [sys_pkg::TIMESTAMP_W-1:0] timestamp
);

	sys_pkg::bus_req_t req;
	sys_pkg::byte_t mem_rdata;
	sys_pkg::byte_t io_rdata;
	logic done;

	bus_decoder u_bus_decoder (
		.clk_24(clk_24),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.done(done),
		.req(req)
	);

	// rom, work ram and character side rams
	memory_banks u_memory_banks (
		.clk_24(clk_24),
		.reset(reset),
		.req(req),
		.dl(dl),
		.mem_rdata(mem_rdata)
	);

	// inputs and ms timer
	input_ports u_input_ports (
		.clk_24(clk_24),
		.reset(reset),
		.req(req),
		.joystick(joystick),
		.paddle(paddle),
		.ps2_key(ps2_key),
		.timestamp(timestamp),
		.io_rdata(io_rdata)
	);

	read_response u_read_response (
		.clk_24(clk_24),
		.reset(reset),
		.req(req),
		.mem_rdata(mem_rdata),
		.io_rdata(io_rdata),
		.dat_r(dat_r),
		.ack(ack),
		.done(done)
	);

endmodule

// ==== tb.f ====
+incdir+dv
logic/sys_pkg.sv
logic/bus_decoder.sv
logic/memory_banks.sv
logic/input_ports.sv
logic/read_response.sv
logic/system_top.sv
dv/system_props.sv
dv/tb_top.sv
